// ==== boot_ctrl.sv ====
`timescale 1ns/1ps

module boot_ctrl (
   input  logic                      clk_i,
   input  logic                      rst_i,
   iob_bus_if.slave                  dbus,
   iob_bus_if.slave                  ibus,
   output soc_fabric_pkg::boot_ctr_t boot_ctr_o,
   output logic                      cpu_rst_o
);
   import soc_fabric_pkg::*;

   boot_ctr_t         ctr_q;
   logic              cpu_rst_q;
   logic              d_rd;
   logic              d_wr;
   logic [3:0]        d_ofs;
   logic [DATA_W-1:0] d_rdata_q;
   logic              d_rvalid_q;

   logic [DATA_W-1:0] rom [2**ROM_ADDR_W];
   logic [DATA_W-1:0] i_rdata_q;
   logic              i_rvalid_q;

   initial begin
      $readmemh("boot_rom.hex", rom);
   end

   assign d_ofs = dbus.addr[3:0];
   assign d_rd  = dbus.avalid && dbus.ready && (dbus.wstrb == '0);
   assign d_wr  = dbus.avalid && dbus.ready && (dbus.wstrb != '0);

   // Control registers
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctr_q      <= BOOT_ROM;
         cpu_rst_q  <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         if (d_wr && (d_ofs == REG_CTR_OFS)) begin
            ctr_q <= boot_ctr_t'(dbus.wdata[1:0]);
         end
         // Strobe lasts one cycle unless written again
         cpu_rst_q  <= d_wr && (d_ofs == REG_CPU_RST_OFS) && dbus.wdata[0];
         d_rvalid_q <= d_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (d_rd) begin
         d_rdata_q <= (d_ofs == REG_CTR_OFS) ? DATA_W'(ctr_q) : '0;
      end
   end

   // Boot ROM on the instruction side
   always_ff @(posedge clk_i) begin
      i_rdata_q <= rom[ibus.addr[ROM_ADDR_W+1:2]];
      if (rst_i) begin
         i_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= ibus.avalid && ibus.ready;
      end
   end

   assign dbus.ready  = 1'b1;
   assign dbus.rdata  = d_rdata_q;
   assign dbus.rvalid = d_rvalid_q;

   assign ibus.ready  = 1'b1;
   assign ibus.rdata  = i_rdata_q;
   assign ibus.rvalid = i_rvalid_q;

   assign boot_ctr_o = ctr_q;
   // Processor held in reset with the fabric, then pulsed by software
   assign cpu_rst_o  = rst_i | cpu_rst_q;

endmodule

// ==== boot_rom.hex ====
// Boot ROM image: one 32-bit word per line in hex, word address 0 to 15
00000093
00000113
800001b7
00100213
0041a023
0001a283
c0000337
00532023
00032383
fe038ee3
00000013
00000013
10500073
0040006f
ff9ff06f
0000006f

// ==== bus_split.sv ====
`timescale 1ns/1ps

module bus_split #(
   parameter int N = 2
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [$clog2(N)-1:0] f_sel_i,
   iob_bus_if.slave             m,
   iob_bus_if.master            f [N]
);
   import soc_fabric_pkg::*;

   logic [N-1:0]         f_avalid;
   logic [N-1:0]         f_ready;
   logic [N-1:0]         f_rvalid;
   logic [DATA_W-1:0]    f_rdata [N];
   logic [$clog2(N)-1:0] rsp_sel_q;
   logic                 rd_acc;

   // Request fan-out and response gather per follower
   for (genvar i = 0; i < N; i++) begin : g_fol
      assign f_avalid[i] = m.avalid && (f_sel_i == i);

      assign f[i].avalid = f_avalid[i];
      assign f[i].addr   = m.addr;
      assign f[i].wdata  = m.wdata;
      assign f[i].wstrb  = m.wstrb;

      assign f_ready[i]  = f[i].ready;
      assign f_rvalid[i] = f[i].rvalid;
      assign f_rdata[i]  = f[i].rdata;
   end

   // Acceptance follows the follower addressed in this cycle
   assign m.ready = f_ready[f_sel_i];

   assign rd_acc = m.avalid && m.ready && (m.wstrb == '0);

   // Remember who owes the next read response
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rsp_sel_q <= '0;
      end else if (rd_acc) begin
         rsp_sel_q <= f_sel_i;
      end
   end

   // Response comes from the latched follower, not the current select
   assign m.rdata  = f_rdata[rsp_sel_q];
   assign m.rvalid = f_rvalid[rsp_sel_q];

   a_one_follower: assert property (
      @(posedge clk_i) disable iff (rst_i)
      $onehot0(f_avalid)
   ) else $error("bus_split: more than one follower request active");

   // Followers must answer every accepted read in the next cycle
   a_read_rsp: assert property (
      @(posedge clk_i) disable iff (rst_i)
      rd_acc |=> m.rvalid
   ) else $error("bus_split: accepted read got no rvalid");

endmodule

// ==== iob_bus_if.sv ====
`timescale 1ns/1ps

interface iob_bus_if;
   import soc_fabric_pkg::*;

   // Request
   logic              avalid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   // All zero strobes mean a read
   logic [STRB_W-1:0] wstrb;

   // Response
   logic [DATA_W-1:0] rdata;
   logic              rvalid;
   logic              ready;

   modport master (
      output avalid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  rvalid,
      input  ready
   );

   modport slave (
      input  avalid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output rvalid,
      output ready
   );

endinterface

// ==== soc_fabric.f ====
soc_fabric_pkg.sv
iob_bus_if.sv
bus_split.sv
boot_ctrl.sv
soc_sram.sv
soc_timer.sv
soc_fabric_top.sv
tb_soc_fabric.sv

// ==== soc_fabric_pkg.sv ====
package soc_fabric_pkg;

   // Native bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Word address bits of the on-chip memories
   localparam int SRAM_ADDR_W = 8;
   localparam int ROM_ADDR_W  = 4;

   // Address map
   // Bit 31 splits SRAM from peripherals, bit 30 picks the peripheral
   localparam int N_PERIPHS      = 2;
   localparam int MEM_SEL_BIT    = 31;
   localparam int PERIPH_SEL_BIT = 30;

   // Boot control register offsets
   localparam logic [3:0] REG_CTR_OFS     = 4'h0;
   localparam logic [3:0] REG_CPU_RST_OFS = 4'h4;

   // Timer register offsets
   localparam logic [3:0] TMR_CTRL_OFS  = 4'h0;
   localparam logic [3:0] TMR_VALUE_OFS = 4'h4;

   // Boot control field
   // Only BOOT_ROM fetches from the ROM, every other value uses the SRAM
   typedef logic [1:0] boot_ctr_t;

   localparam boot_ctr_t BOOT_ROM = 2'b00;

endpackage

// ==== soc_fabric_top.sv ====
`timescale 1ns/1ps

module soc_fabric_top (
   input  logic                                clk_i,
   input  logic                                rst_i,

   // Instruction bus
   input  logic                                ibus_avalid_i,
   input  logic [soc_fabric_pkg::ADDR_W-1:0]   ibus_addr_i,
   output logic [soc_fabric_pkg::DATA_W-1:0]   ibus_rdata_o,
   output logic                                ibus_rvalid_o,
   output logic                                ibus_ready_o,

   // Data bus
   input  logic                                dbus_avalid_i,
   input  logic [soc_fabric_pkg::ADDR_W-1:0]   dbus_addr_i,
   input  logic [soc_fabric_pkg::DATA_W-1:0]   dbus_wdata_i,
   input  logic [soc_fabric_pkg::STRB_W-1:0]   dbus_wstrb_i,
   output logic [soc_fabric_pkg::DATA_W-1:0]   dbus_rdata_o,
   output logic                                dbus_rvalid_o,
   output logic                                dbus_ready_o,

   output logic                                cpu_rst_o
);
   import soc_fabric_pkg::*;

   boot_ctr_t boot_ctr;
   logic      ibus_sel;
   logic      dbus_sel;
   logic      pbus_sel;

   iob_bus_if ibus ();
   iob_bus_if dbus ();
   // ibus_f: 0 boot ROM, 1 SRAM
   iob_bus_if ibus_f [2] ();
   // dbus_f: 0 SRAM, 1 peripheral bus
   iob_bus_if dbus_f [2] ();
   // pbus_f: 0 boot control, 1 timer
   iob_bus_if pbus_f [N_PERIPHS] ();

   // Fetch side has no write path
   assign ibus.avalid   = ibus_avalid_i;
   assign ibus.addr     = ibus_addr_i;
   assign ibus.wdata    = '0;
   assign ibus.wstrb    = '0;
   assign ibus_rdata_o  = ibus.rdata;
   assign ibus_rvalid_o = ibus.rvalid;
   assign ibus_ready_o  = ibus.ready;

   assign dbus.avalid   = dbus_avalid_i;
   assign dbus.addr     = dbus_addr_i;
   assign dbus.wdata    = dbus_wdata_i;
   assign dbus.wstrb    = dbus_wstrb_i;
   assign dbus_rdata_o  = dbus.rdata;
   assign dbus_rvalid_o = dbus.rvalid;
   assign dbus_ready_o  = dbus.ready;

   // Follower selects
   assign ibus_sel = (boot_ctr != BOOT_ROM);
   assign dbus_sel = dbus_addr_i[MEM_SEL_BIT];
   assign pbus_sel = dbus_f[1].addr[PERIPH_SEL_BIT];

   bus_split #(.N(2)) u_ibus_split (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .f_sel_i(ibus_sel),
      .m      (ibus),
      .f      (ibus_f)
   );

   bus_split #(.N(2)) u_dbus_split (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .f_sel_i(dbus_sel),
      .m      (dbus),
      .f      (dbus_f)
   );

   bus_split #(.N(N_PERIPHS)) u_pbus_split (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .f_sel_i(pbus_sel),
      .m      (dbus_f[1]),
      .f      (pbus_f)
   );

   boot_ctrl u_boot_ctrl (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .dbus      (pbus_f[0]),
      .ibus      (ibus_f[0]),
      .boot_ctr_o(boot_ctr),
      .cpu_rst_o (cpu_rst_o)
   );

   soc_sram u_sram (
      .clk_i(clk_i),
      .ibus (ibus_f[1]),
      .dbus (dbus_f[0])
   );

   soc_timer u_timer (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .bus  (pbus_f[1])
   );

endmodule

// ==== soc_sram.sv ====
`timescale 1ns/1ps

module soc_sram (
   input  logic     clk_i,
   iob_bus_if.slave ibus,
   iob_bus_if.slave dbus
);
   import soc_fabric_pkg::*;

   logic [DATA_W-1:0]      mem [2**SRAM_ADDR_W];
   logic [SRAM_ADDR_W-1:0] i_idx;
   logic [SRAM_ADDR_W-1:0] d_idx;
   logic [DATA_W-1:0]      i_rdata_q;
   logic                   i_rvalid_q;
   logic [DATA_W-1:0]      d_rdata_q;
   logic                   d_rvalid_q;

   // Word index from the byte address
   assign i_idx = ibus.addr[SRAM_ADDR_W+1:2];
   assign d_idx = dbus.addr[SRAM_ADDR_W+1:2];

   // Instruction port is read only
   always_ff @(posedge clk_i) begin
      i_rdata_q  <= mem[i_idx];
      i_rvalid_q <= ibus.avalid;
   end

   // Data port with byte lanes
   always_ff @(posedge clk_i) begin
      if (dbus.avalid) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (dbus.wstrb[b]) begin
               mem[d_idx][8*b +: 8] <= dbus.wdata[8*b +: 8];
            end
         end
      end
      d_rdata_q  <= mem[d_idx];
      d_rvalid_q <= dbus.avalid && (dbus.wstrb == '0);
   end

   assign ibus.ready  = 1'b1;
   assign ibus.rdata  = i_rdata_q;
   assign ibus.rvalid = i_rvalid_q;

   assign dbus.ready  = 1'b1;
   assign dbus.rdata  = d_rdata_q;
   assign dbus.rvalid = d_rvalid_q;

   // Fetch path is tied off as read only at the top
   a_ibus_no_write: assert property (
      @(posedge clk_i)
      ibus.avalid |-> (ibus.wstrb == '0)
   ) else $error("soc_sram: write strobe seen on instruction port");

endmodule

// ==== soc_timer.sv ====
`timescale 1ns/1ps

module soc_timer (
   input  logic     clk_i,
   input  logic     rst_i,
   iob_bus_if.slave bus
);
   import soc_fabric_pkg::*;

   logic              en_q;
   logic [DATA_W-1:0] value_q;
   logic [3:0]        ofs;
   logic              rd;
   logic              wr;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   assign ofs = bus.addr[3:0];
   assign rd  = bus.avalid && bus.ready && (bus.wstrb == '0);
   assign wr  = bus.avalid && bus.ready && (bus.wstrb != '0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         en_q     <= 1'b0;
         value_q  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr && (ofs == TMR_CTRL_OFS)) begin
            en_q <= bus.wdata[0];
         end
         // A load wins over counting
         if (wr && (ofs == TMR_VALUE_OFS)) begin
            value_q <= bus.wdata;
         end else if (en_q) begin
            value_q <= value_q + 1'b1;
         end
         rvalid_q <= rd;
      end
   end

   // Snapshot taken at acceptance
   always_ff @(posedge clk_i) begin
      if (rd) begin
         rdata_q <= (ofs == TMR_CTRL_OFS) ? DATA_W'(en_q) : value_q;
      end
   end

   assign bus.ready  = 1'b1;
   assign bus.rdata  = rdata_q;
   assign bus.rvalid = rvalid_q;

endmodule

// ==== tb_soc_fabric.sv ====
`timescale 1ns/1ps

module tb_soc_fabric;
   import soc_fabric_pkg::*;

   // Bus accesses over all tests, with headroom
   localparam int N_ACCESSES = 64;
   localparam int TIMER_GAP  = 7;

   logic              clk;
   logic              rst;
   logic              ibus_avalid;
   logic [ADDR_W-1:0] ibus_addr;
   logic [DATA_W-1:0] ibus_rdata;
   logic              ibus_rvalid;
   logic              ibus_ready;
   logic              dbus_avalid;
   logic [ADDR_W-1:0] dbus_addr;
   logic [DATA_W-1:0] dbus_wdata;
   logic [STRB_W-1:0] dbus_wstrb;
   logic [DATA_W-1:0] dbus_rdata;
   logic              dbus_rvalid;
   logic              dbus_ready;
   logic              cpu_rst;

   logic [DATA_W-1:0] rom_model [16];
   logic [DATA_W-1:0] sram_model [2**SRAM_ADDR_W];
   logic [ADDR_W-1:0] sram_addr [4];
   logic [ADDR_W-1:0] rd_addr [16];
   logic [DATA_W-1:0] rd_data [16];
   logic              rd_ok [16];
   logic [31:0]       lfsr_q;
   logic [DATA_W-1:0] timer_frozen;
   int                err_count;
   int                tests_run;
   int                tests_failed;

   soc_fabric_top u_dut (
      .clk_i        (clk),
      .rst_i        (rst),
      .ibus_avalid_i(ibus_avalid),
      .ibus_addr_i  (ibus_addr),
      .ibus_rdata_o (ibus_rdata),
      .ibus_rvalid_o(ibus_rvalid),
      .ibus_ready_o (ibus_ready),
      .dbus_avalid_i(dbus_avalid),
      .dbus_addr_i  (dbus_addr),
      .dbus_wdata_i (dbus_wdata),
      .dbus_wstrb_i (dbus_wstrb),
      .dbus_rdata_o (dbus_rdata),
      .dbus_rvalid_o(dbus_rvalid),
      .dbus_ready_o (dbus_ready),
      .cpu_rst_o    (cpu_rst)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   // Bit 31 high for peripherals, bit 30 picks the timer
   function automatic logic [ADDR_W-1:0] periph_addr(input logic sel, input logic [3:0] ofs);
      return {1'b1, sel, 26'd0, ofs};
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] r;
      r = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            r[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return r;
   endfunction

   task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                           input string what);
      assert (got === exp) else begin
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic expect_read(input int k, input logic [DATA_W-1:0] exp, input string what);
      assert (rd_ok[k] === 1'b1) else begin
         $display("ERROR: %s got no rvalid in the cycle after acceptance (time %0t ns)",
                  what, $time);
         err_count++;
      end
      if (rd_ok[k] === 1'b1) begin
         check_eq(rd_data[k], exp, what);
      end
   endtask

   // Pipelined reads of rd_addr[0..n-1], one request per cycle
   task automatic read_burst(input bit on_ibus, input int n);
      for (int k = 0; k <= n; k++) begin
         @(posedge clk);
         if (on_ibus) begin
            ibus_avalid <= (k < n);
            ibus_addr   <= (k < n) ? rd_addr[k] : '0;
         end else begin
            dbus_avalid <= (k < n);
            dbus_addr   <= (k < n) ? rd_addr[k] : '0;
            dbus_wstrb  <= '0;
         end
         @(negedge clk);
         if (k < n) begin
            assert ((on_ibus ? ibus_ready : dbus_ready) === 1'b1) else begin
               $display("ERROR: bus not ready for read %0d at time %0t ns", k, $time);
               err_count++;
            end
         end
         if (k > 0) begin
            rd_ok[k-1]   = on_ibus ? ibus_rvalid : dbus_rvalid;
            rd_data[k-1] = on_ibus ? ibus_rdata : dbus_rdata;
         end
      end
   endtask

   // Returns just after the accepting edge
   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
      @(posedge clk);
      dbus_avalid <= 1'b1;
      dbus_addr   <= addr;
      dbus_wdata  <= data;
      dbus_wstrb  <= strb;
      @(negedge clk);
      assert (dbus_ready === 1'b1) else begin
         $display("ERROR: bus not ready for write to %h at time %0t ns", addr, $time);
         err_count++;
      end
      @(posedge clk);
      dbus_avalid <= 1'b0;
      dbus_wstrb  <= '0;
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         $display("[ok]   %s", name);
      end else begin
         tests_failed++;
         $display("[bad]  %s (%0d errors)", name, err_count - errs_before);
      end
   endtask

   task automatic test_rom_boot();
      int e;
      e = err_count;
      @(negedge clk);
      check_eq(DATA_W'(cpu_rst), '0, "cpu_rst_o after reset");
      for (int i = 0; i < 16; i++) begin
         rd_addr[i] = ADDR_W'(4 * i);
      end
      read_burst(1'b1, 16);
      for (int i = 0; i < 16; i++) begin
         expect_read(i, rom_model[i], $sformatf("rom word %0d", i));
      end
      end_test("rom_boot", e);
   endtask

   task automatic test_sram_rw();
      int                e;
      logic [7:0]        idx;
      logic [DATA_W-1:0] w;
      logic [STRB_W-1:0] s;
      e = err_count;
      for (int i = 0; i < 4; i++) begin
         idx          = rand_bits(8);
         w            = rand_bits(32);
         sram_addr[i] = {22'd0, idx, 2'b00};
         write_word(sram_addr[i], w, 4'hf);
         sram_model[idx] = w;
      end
      // Partial strobes over words already written in full
      for (int i = 0; i < 4; i++) begin
         idx = sram_addr[i][9:2];
         w   = rand_bits(32);
         s   = rand_bits(4);
         if (s == '0) begin
            s = 4'b0101;
         end
         write_word(sram_addr[i], w, s);
         sram_model[idx] = merge_bytes(sram_model[idx], w, s);
      end
      for (int i = 0; i < 4; i++) begin
         rd_addr[i] = sram_addr[i];
      end
      read_burst(1'b0, 4);
      for (int i = 0; i < 4; i++) begin
         expect_read(i, sram_model[sram_addr[i][9:2]], $sformatf("sram read %0d", i));
      end
      end_test("sram_rw", e);
   endtask

   task automatic test_boot_switch();
      int e;
      e = err_count;
      write_word(periph_addr(1'b0, REG_CTR_OFS), 32'h1, 4'hf);
      rd_addr[0] = periph_addr(1'b0, REG_CTR_OFS);
      read_burst(1'b0, 1);
      expect_read(0, 32'h1, "CTR read");
      for (int i = 0; i < 4; i++) begin
         rd_addr[i] = sram_addr[i];
      end
      read_burst(1'b1, 4);
      for (int i = 0; i < 4; i++) begin
         expect_read(i, sram_model[sram_addr[i][9:2]], $sformatf("sram fetch %0d", i));
      end
      write_word(periph_addr(1'b0, REG_CTR_OFS), 32'h0, 4'hf);
      for (int i = 0; i < 4; i++) begin
         rd_addr[i] = ADDR_W'(4 * i);
      end
      read_burst(1'b1, 4);
      for (int i = 0; i < 4; i++) begin
         expect_read(i, rom_model[i], $sformatf("rom fetch %0d", i));
      end
      end_test("boot_switch", e);
   endtask

   task automatic test_cpu_reset();
      int e;
      e = err_count;
      write_word(periph_addr(1'b0, REG_CPU_RST_OFS), 32'h1, 4'hf);
      @(negedge clk);
      check_eq(DATA_W'(cpu_rst), 32'h1, "cpu_rst_o in strobe cycle");
      repeat (2) begin
         @(negedge clk);
         check_eq(DATA_W'(cpu_rst), 32'h0, "cpu_rst_o after strobe");
      end
      end_test("cpu_reset", e);
   endtask

   task automatic test_timer();
      int                e;
      logic [DATA_W-1:0] load_val;
      logic [DATA_W-1:0] v1;
      e = err_count;
      load_val = rand_bits(32);
      write_word(periph_addr(1'b1, TMR_VALUE_OFS), load_val, 4'hf);
      write_word(periph_addr(1'b1, TMR_CTRL_OFS), 32'h1, 4'hf);
      rd_addr[0] = periph_addr(1'b1, TMR_VALUE_OFS);
      read_burst(1'b0, 1);
      // One count lands between the enable write and the read
      expect_read(0, load_val + 1, "first VALUE read");
      v1 = rd_data[0];
      // Back-to-back single reads are accepted two cycles apart
      repeat (TIMER_GAP - 2) @(posedge clk);
      read_burst(1'b0, 1);
      expect_read(0, v1 + TIMER_GAP, "counting VALUE delta");
      write_word(periph_addr(1'b1, TMR_CTRL_OFS), 32'h0, 4'hf);
      read_burst(1'b0, 1);
      v1 = rd_data[0];
      repeat (3) @(posedge clk);
      read_burst(1'b0, 1);
      expect_read(0, v1, "stopped VALUE");
      timer_frozen = v1;
      end_test("timer", e);
   endtask

   task automatic test_interleave();
      int e;
      e = err_count;
      write_word(periph_addr(1'b0, REG_CTR_OFS), 32'h2, 4'hf);
      rd_addr[0] = sram_addr[0];
      rd_addr[1] = periph_addr(1'b0, REG_CTR_OFS);
      rd_addr[2] = periph_addr(1'b1, TMR_VALUE_OFS);
      rd_addr[3] = sram_addr[1];
      rd_addr[4] = periph_addr(1'b1, TMR_CTRL_OFS);
      rd_addr[5] = periph_addr(1'b0, REG_CPU_RST_OFS);
      rd_addr[6] = sram_addr[2];
      read_burst(1'b0, 7);
      expect_read(0, sram_model[sram_addr[0][9:2]], "mixed sram 0");
      expect_read(1, 32'h2, "mixed CTR");
      expect_read(2, timer_frozen, "mixed timer VALUE");
      expect_read(3, sram_model[sram_addr[1][9:2]], "mixed sram 1");
      expect_read(4, 32'h0, "mixed timer CTRL");
      expect_read(5, 32'h0, "mixed CPU_RST");
      expect_read(6, sram_model[sram_addr[2][9:2]], "mixed sram 2");
      write_word(periph_addr(1'b0, REG_CTR_OFS), 32'h0, 4'hf);
      end_test("interleave", e);
   endtask

   initial begin
      repeat (N_ACCESSES * 20) @(posedge clk);
      $display("ERROR: watchdog expired before the tests finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      ibus_avalid  = 1'b0;
      ibus_addr    = '0;
      dbus_avalid  = 1'b0;
      dbus_addr    = '0;
      dbus_wdata   = '0;
      dbus_wstrb   = '0;
      lfsr_q       = 32'h6e0190de;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      $readmemh("boot_rom.hex", rom_model);
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      test_rom_boot();
      test_sram_rw();
      test_boot_switch();
      test_cpu_reset();
      test_timer();
      test_interleave();

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
